// File: compile.f
exu_pkg.sv
integer_unit.sv
csr_unit.sv
load_unit.sv
store_buffer.sv
mem_arbiter.sv
data_memory.sv
execution_unit.sv
tb_clock_gen.sv
tb_execution_unit.sv

// File: csr_unit.sv
`timescale 1ns/1ps

module csr_unit import exu_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       valid_i,
    input  csr_op_t    opcode_i,
    input  tag_t       tag_i,
    input  csr_addr_t  addr_i,
    input  data_word_t wdata_i,
    input  logic       machine_return_i,
    output logic       valid_o,
    output tag_t       tag_o,
    output data_word_t rdata_o,
    output logic       illegal_o
);

    data_word_t uscratch_q;
    data_word_t mscratch_q;
    data_word_t mstatus_q;
    priv_t      priv_q;
    data_word_t csr_old;
    data_word_t csr_new;
    logic       illegal;
    logic       csr_we;

    //==============================
    // Read and modify
    //==============================

    always_comb begin
        case (addr_i)
            CSR_USCRATCH: csr_old = uscratch_q;
            CSR_MSCRATCH: csr_old = mscratch_q;
            CSR_MSTATUS:  csr_old = mstatus_q;
            default:      csr_old = {31'b0, logic'(priv_q)};
        endcase
    end

    always_comb begin
        case (opcode_i)
            CSR_SWAP:  csr_new = wdata_i;
            CSR_SET:   csr_new = csr_old | wdata_i;
            CSR_CLEAR: csr_new = csr_old & ~wdata_i;
            default:   csr_new = csr_old;
        endcase
    end

    // Every CSR except the user scratch belongs to machine mode
    assign illegal = (priv_q == PRIV_USER) && (addr_i != CSR_USCRATCH);
    assign csr_we  = valid_i && !illegal && (opcode_i != CSR_READ);

    //==============================
    // Register file and privilege
    //==============================

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            uscratch_q <= '0;
            mscratch_q <= '0;
            mstatus_q  <= '0;
            priv_q     <= PRIV_MACHINE;
        end else begin
            if (csr_we) begin
                case (addr_i)
                    CSR_USCRATCH: uscratch_q <= csr_new;
                    CSR_MSCRATCH: mscratch_q <= csr_new;
                    CSR_MSTATUS:  mstatus_q  <= csr_new;
                    default:      priv_q     <= priv_t'(csr_new[0]);
                endcase
            end
            // A return from the trap handler wins over a write in the same cycle
            if (machine_return_i) begin
                priv_q <= PRIV_MACHINE;
            end
        end
    end

    // The result carries the value from before the update
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o   <= 1'b0;
            illegal_o <= 1'b0;
        end else begin
            valid_o   <= valid_i;
            illegal_o <= valid_i && illegal;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            tag_o   <= tag_i;
            rdata_o <= illegal ? '0 : csr_old;
        end
    end

    // User code must not lift itself back into machine mode
    a_priv_rise : assert property (@(posedge clk_i) disable iff (rst_i)
        (priv_q == PRIV_USER) |=> (priv_q == PRIV_USER) || $past(machine_return_i))
        else $error("Privilege rose without a machine return");

endmodule : csr_unit

// File: data_memory.sv
`timescale 1ns/1ps

module data_memory import exu_pkg::*; #(
    parameter int MEM_DEPTH_LOG2 = 6
) (
    input  logic                      clk_i,
    input  logic                      we_i,
    input  logic [MEM_DEPTH_LOG2-1:0] addr_i,
    input  data_word_t                wdata_i,
    output data_word_t                rdata_o
);

    localparam int DEPTH = 1 << MEM_DEPTH_LOG2;

    // Word array that starts out cleared
    data_word_t mem_q [DEPTH] = '{default: '0};

    // Registered read gives the data one cycle after the access
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[addr_i] <= wdata_i;
        end
        rdata_o <= mem_q[addr_i];
    end

endmodule : data_memory

// File: execution_unit.sv
`timescale 1ns/1ps

module execution_unit import exu_pkg::*; #(
    parameter int STORE_BUFFER_SIZE = 8,
    parameter int MEM_DEPTH_LOG2    = 6
) (
    input  logic       clk_i,
    input  logic       rst_i,

    // Issue port
    input  logic       issue_valid_i,
    input  exu_unit_t  issue_unit_i,
    input  logic [2:0] issue_opcode_i,
    input  tag_t       issue_tag_i,
    input  data_word_t operand_a_i,
    input  data_word_t operand_b_i,
    input  logic       machine_return_i,

    // Integer results
    output logic       itu_valid_o,
    output tag_t       itu_tag_o,
    output data_word_t itu_result_o,

    // Load results and credits
    output logic       ldu_valid_o,
    output tag_t       ldu_tag_o,
    output data_word_t ldu_data_o,
    output logic       ld_credit_o,
    output logic       st_credit_o,

    // CSR results
    output logic       csr_valid_o,
    output tag_t       csr_tag_o,
    output data_word_t csr_result_o,
    output logic       csr_illegal_o
);

    logic                      itu_issue;
    logic                      ld_issue;
    logic                      st_issue;
    logic                      csr_issue;
    logic                      ld_req;
    logic                      ld_gnt;
    logic [MEM_DEPTH_LOG2-1:0] ld_addr;
    logic                      st_req;
    logic                      st_gnt;
    logic [MEM_DEPTH_LOG2-1:0] st_addr;
    data_word_t                st_wdata;
    logic                      sb_empty;
    logic                      mem_we;
    logic [MEM_DEPTH_LOG2-1:0] mem_addr;
    data_word_t                mem_wdata;
    data_word_t                mem_rdata;

    //==============================
    // Issue decode
    //==============================

    assign itu_issue = issue_valid_i && (issue_unit_i == UNIT_ITU);
    assign ld_issue  = issue_valid_i && (issue_unit_i == UNIT_LOAD);
    assign st_issue  = issue_valid_i && (issue_unit_i == UNIT_STORE);
    assign csr_issue = issue_valid_i && (issue_unit_i == UNIT_CSR);

    integer_unit integer_unit_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .valid_i     (itu_issue),
        .opcode_i    (itu_op_t'(issue_opcode_i)),
        .tag_i       (issue_tag_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .valid_o     (itu_valid_o),
        .tag_o       (itu_tag_o),
        .result_o    (itu_result_o)
    );

    // Operand B low bits select the CSR and operand A is the source
    csr_unit csr_unit_i (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .valid_i          (csr_issue),
        .opcode_i         (csr_op_t'(issue_opcode_i[1:0])),
        .tag_i            (issue_tag_i),
        .addr_i           (operand_b_i[1:0]),
        .wdata_i          (operand_a_i),
        .machine_return_i (machine_return_i),
        .valid_o          (csr_valid_o),
        .tag_o            (csr_tag_o),
        .rdata_o          (csr_result_o),
        .illegal_o        (csr_illegal_o)
    );

    //==============================
    // Load and store path
    //==============================

    // Word addresses wrap modulo the memory depth
    load_unit #(.MEM_DEPTH_LOG2(MEM_DEPTH_LOG2)) load_unit_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .valid_i     (ld_issue),
        .tag_i       (issue_tag_i),
        .addr_i      (operand_a_i[MEM_DEPTH_LOG2-1:0]),
        .sb_empty_i  (sb_empty),
        .gnt_i       (ld_gnt),
        .mem_rdata_i (mem_rdata),
        .req_o       (ld_req),
        .addr_o      (ld_addr),
        .valid_o     (ldu_valid_o),
        .tag_o       (ldu_tag_o),
        .data_o      (ldu_data_o),
        .credit_o    (ld_credit_o)
    );

    store_buffer #(
        .STORE_BUFFER_SIZE (STORE_BUFFER_SIZE),
        .MEM_DEPTH_LOG2    (MEM_DEPTH_LOG2)
    ) store_buffer_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .valid_i     (st_issue),
        .addr_i      (operand_a_i[MEM_DEPTH_LOG2-1:0]),
        .data_i      (operand_b_i),
        .gnt_i       (st_gnt),
        .req_o       (st_req),
        .mem_addr_o  (st_addr),
        .mem_wdata_o (st_wdata),
        .empty_o     (sb_empty),
        .credit_o    (st_credit_o)
    );

    mem_arbiter #(.MEM_DEPTH_LOG2(MEM_DEPTH_LOG2)) mem_arbiter_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .ld_req_i    (ld_req),
        .ld_addr_i   (ld_addr),
        .st_req_i    (st_req),
        .st_addr_i   (st_addr),
        .st_wdata_i  (st_wdata),
        .ld_gnt_o    (ld_gnt),
        .st_gnt_o    (st_gnt),
        .mem_we_o    (mem_we),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata)
    );

    data_memory #(.MEM_DEPTH_LOG2(MEM_DEPTH_LOG2)) data_memory_i (
        .clk_i   (clk_i),
        .we_i    (mem_we),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata)
    );

endmodule : execution_unit

// File: execution_unit_stim.txt
// unit opcode tag operand_a operand_b flags expected
// flags: 1 illegal expected, 2 machine return first, 4 back to back, 8 drain first
0 0 1 00000005 00000003 0 00000008
0 1 2 00000003 00000005 4 FFFFFFFE
0 2 3 F0F0F0F0 0FF00FF0 4 00F000F0
0 3 4 F0F0F0F0 0FF00FF0 4 FFF0FFF0
0 4 5 F0F0F0F0 0FF00FF0 4 FF00FF00
0 5 6 00000001 0000001F 0 80000000
0 6 7 80000000 FFFFFFFF 0 00000001
0 7 8 FFFFFFFF 00000001 0 00000001
0 7 9 00000001 FFFFFFFF 0 00000000
2 0 A 00000010 11111111 8 00000000
2 0 B 00000010 22222222 4 00000000
2 0 C 00000011 44444444 4 00000000
2 0 D 00000010 33333333 4 00000000
2 0 E 00000012 55555555 4 00000000
2 0 F 00000013 66666666 4 00000000
2 0 0 00000052 88888888 4 00000000
2 0 1 00000010 77777777 4 00000000
1 0 A 00000010 00000000 4 77777777
1 0 B 00000012 00000000 0 88888888
1 0 C 00000020 00000000 0 00000000
3 1 D A5A5A5A5 00000000 8 00000000
3 0 E 00000000 00000000 0 A5A5A5A5
3 2 F 0000000F 00000002 0 00000000
3 2 0 000000F0 00000002 0 0000000F
3 3 1 00000003 00000002 0 000000FF
3 0 2 00000000 00000002 0 000000FC
3 1 3 12345678 00000001 0 00000000
3 3 4 00000001 00000003 0 00000001
3 0 5 00000000 00000001 1 00000000
3 1 6 DEADBEEF 00000001 1 00000000
3 1 7 00C0FFEE 00000000 0 A5A5A5A5
3 0 8 00000000 00000000 0 00C0FFEE
3 0 9 00000000 00000001 2 12345678
3 0 A 00000000 00000003 0 00000001
0 0 B FFFFFFFF 00000001 0 00000000
1 0 C 00000011 00000000 4 44444444
3 0 D 00000000 00000002 4 000000FC
0 1 E 00000000 00000001 4 FFFFFFFF
F 0 0 00000000 00000000 0 00000000

// File: exu_pkg.sv
package exu_pkg;

    //==============================
    // Datapath types
    //==============================

    // One machine word as carried by operands and results
    typedef logic [31:0] data_word_t;

    // Tag that each unit hands back with its result
    typedef logic [3:0] tag_t;

    // Functional unit selected by the issue port
    typedef enum logic [1:0] {
        UNIT_ITU,
        UNIT_LOAD,
        UNIT_STORE,
        UNIT_CSR
    } exu_unit_t;

    // Integer operations where shifts take the low 5 bits of operand B
    typedef enum logic [2:0] {
        ITU_ADD,
        ITU_SUB,
        ITU_AND,
        ITU_OR,
        ITU_XOR,
        ITU_SLL,
        ITU_SRL,
        ITU_SLT
    } itu_op_t;

    //==============================
    // Control and status registers
    //==============================

    // Read-modify-write flavours of a CSR access
    typedef enum logic [1:0] {
        CSR_READ,
        CSR_SWAP,
        CSR_SET,
        CSR_CLEAR
    } csr_op_t;

    typedef logic [1:0] csr_addr_t;

    // Only the user scratch register is open to user mode
    localparam csr_addr_t CSR_USCRATCH = 2'd0;
    localparam csr_addr_t CSR_MSCRATCH = 2'd1;
    localparam csr_addr_t CSR_MSTATUS  = 2'd2;
    // Bit 0 mirrors the current privilege level
    localparam csr_addr_t CSR_PRIV     = 2'd3;

    typedef enum logic {
        PRIV_USER,
        PRIV_MACHINE
    } priv_t;

    //==============================
    // Load unit FSM
    //==============================

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_DRAIN,
        LD_REQ,
        LD_RESP
    } load_state_t;

endpackage : exu_pkg

// File: integer_unit.sv
`timescale 1ns/1ps

module integer_unit import exu_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       valid_i,
    input  itu_op_t    opcode_i,
    input  tag_t       tag_i,
    input  data_word_t operand_a_i,
    input  data_word_t operand_b_i,
    output logic       valid_o,
    output tag_t       tag_o,
    output data_word_t result_o
);

    // Shift amount is limited to the word width
    logic [4:0] shamt;
    data_word_t alu_result;

    assign shamt = operand_b_i[4:0];

    //==============================
    // ALU
    //==============================

    always_comb begin
        case (opcode_i)
            ITU_ADD: alu_result = operand_a_i + operand_b_i;
            ITU_SUB: alu_result = operand_a_i - operand_b_i;
            ITU_AND: alu_result = operand_a_i & operand_b_i;
            ITU_OR:  alu_result = operand_a_i | operand_b_i;
            ITU_XOR: alu_result = operand_a_i ^ operand_b_i;
            ITU_SLL: alu_result = operand_a_i << shamt;
            ITU_SRL: alu_result = operand_a_i >> shamt;
            // Compare as two's complement numbers
            default: alu_result = {31'b0, $signed(operand_a_i) < $signed(operand_b_i)};
        endcase
    end

    //==============================
    // Output stage
    //==============================

    // One stage so a new operation may start on every cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // Result and tag only move when an operation is accepted
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            tag_o    <= tag_i;
            result_o <= alu_result;
        end
    end

endmodule : integer_unit

// File: load_unit.sv
`timescale 1ns/1ps

module load_unit import exu_pkg::*; #(
    parameter int MEM_DEPTH_LOG2 = 6
) (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      valid_i,
    input  tag_t                      tag_i,
    input  logic [MEM_DEPTH_LOG2-1:0] addr_i,
    input  logic                      sb_empty_i,
    input  logic                      gnt_i,
    input  data_word_t                mem_rdata_i,
    output logic                      req_o,
    output logic [MEM_DEPTH_LOG2-1:0] addr_o,
    output logic                      valid_o,
    output tag_t                      tag_o,
    output data_word_t                data_o,
    output logic                      credit_o
);

    load_state_t state_q;

    // With no store pending the drain state is skipped entirely
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= LD_IDLE;
        end else begin
            case (state_q)
                LD_IDLE:  if (valid_i) state_q <= sb_empty_i ? LD_REQ : LD_DRAIN;
                LD_DRAIN: if (sb_empty_i) state_q <= LD_REQ;
                LD_REQ:   if (gnt_i) state_q <= LD_RESP;
                default:  state_q <= LD_IDLE;
            endcase
        end
    end

    // Only one load is held at a time
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            tag_o  <= tag_i;
            addr_o <= addr_i;
        end
    end

    assign req_o = (state_q == LD_REQ);

    // Memory read data lands one cycle after the grant
    assign valid_o  = (state_q == LD_RESP);
    assign data_o   = mem_rdata_i;
    assign credit_o = valid_o;

    // The single load credit keeps a second load out while one is in flight
    a_issue_idle : assert property (@(posedge clk_i) disable iff (rst_i)
        valid_i |-> (state_q == LD_IDLE))
        else $error("Load issued while the load unit is busy");

endmodule : load_unit

// File: mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import exu_pkg::*; #(
    parameter int MEM_DEPTH_LOG2 = 6
) (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      ld_req_i,
    input  logic [MEM_DEPTH_LOG2-1:0] ld_addr_i,
    input  logic                      st_req_i,
    input  logic [MEM_DEPTH_LOG2-1:0] st_addr_i,
    input  data_word_t                st_wdata_i,
    output logic                      ld_gnt_o,
    output logic                      st_gnt_o,
    output logic                      mem_we_o,
    output logic [MEM_DEPTH_LOG2-1:0] mem_addr_o,
    output data_word_t                mem_wdata_o
);

    // High when the load unit held the port last
    logic last_ld_q;

    // On a conflict the client that waited longer wins
    assign ld_gnt_o = ld_req_i && !(st_req_i && last_ld_q);
    assign st_gnt_o = st_req_i && !(ld_req_i && !last_ld_q);

    // Out of reset the store side goes first so older writes drain early
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            last_ld_q <= 1'b1;
        end else if (ld_gnt_o) begin
            last_ld_q <= 1'b1;
        end else if (st_gnt_o) begin
            last_ld_q <= 1'b0;
        end
    end

    //==============================
    // Memory port mux
    //==============================

    // A granted store writes and anything else reads
    assign mem_we_o    = st_gnt_o;
    assign mem_addr_o  = st_gnt_o ? st_addr_i : ld_addr_i;
    assign mem_wdata_o = st_wdata_i;

    a_one_grant : assert property (@(posedge clk_i) disable iff (rst_i)
        !(ld_gnt_o && st_gnt_o))
        else $error("Both memory clients granted in one cycle");

endmodule : mem_arbiter

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_execution_unit \
    -f compile.f -o sim_exu > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/sim_exu > sim.log 2>&1
cat sim.log

grep -qx "Verification passed" sim.log && exit 0 || exit 1

// File: store_buffer.sv
`timescale 1ns/1ps

module store_buffer import exu_pkg::*; #(
    parameter int STORE_BUFFER_SIZE = 8,
    parameter int MEM_DEPTH_LOG2    = 6
) (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      valid_i,
    input  logic [MEM_DEPTH_LOG2-1:0] addr_i,
    input  data_word_t                data_i,
    input  logic                      gnt_i,
    output logic                      req_o,
    output logic [MEM_DEPTH_LOG2-1:0] mem_addr_o,
    output data_word_t                mem_wdata_o,
    output logic                      empty_o,
    output logic                      credit_o
);

    localparam int PTR_W = (STORE_BUFFER_SIZE > 1) ? $clog2(STORE_BUFFER_SIZE) : 1;
    localparam int CNT_W = $clog2(STORE_BUFFER_SIZE + 1);

    logic [MEM_DEPTH_LOG2-1:0] addr_mem [STORE_BUFFER_SIZE];
    data_word_t                data_mem [STORE_BUFFER_SIZE];
    logic [PTR_W-1:0]          wr_ptr_q;
    logic [PTR_W-1:0]          rd_ptr_q;
    logic [CNT_W-1:0]          count_q;

    // Pointers wrap at the buffer size which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(STORE_BUFFER_SIZE - 1)) ? '0 : ptr + 1'b1;
    endfunction

    //==============================
    // Pointers and occupancy
    //==============================

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_o <= 1'b0;
        end else begin
            if (valid_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (gnt_i) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            count_q  <= count_q + CNT_W'(valid_i) - CNT_W'(gnt_i);
            // One credit per store that reached memory
            credit_o <= gnt_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            addr_mem[wr_ptr_q] <= addr_i;
            data_mem[wr_ptr_q] <= data_i;
        end
    end

    //==============================
    // Memory side
    //==============================

    // The head entry is offered until the arbiter takes it
    assign req_o       = (count_q != '0);
    assign mem_addr_o  = addr_mem[rd_ptr_q];
    assign mem_wdata_o = data_mem[rd_ptr_q];

    // The head still counts as pending during the cycle of its write
    assign empty_o = (count_q == '0);

    // The sender's store credits must keep pushes away from a full buffer
    a_no_overflow : assert property (@(posedge clk_i) disable iff (rst_i)
        valid_i |-> (count_q < CNT_W'(STORE_BUFFER_SIZE)))
        else $error("Store pushed into a full store buffer");

endmodule : store_buffer

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk_o
);

    // Free running clock that starts low so the first rising edge lands at half a period
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

endmodule : tb_clock_gen

// File: tb_execution_unit.sv
`timescale 1ns/1ps

module tb_execution_unit import exu_pkg::*; ();

    localparam int STORE_BUFFER_SIZE = 8;
    localparam int RESET_CYCLES      = 8;
    localparam int CYCLES_PER_RECORD = 60;
    localparam int MAX_RECORDS       = 64;
    localparam int FIELDS            = 7;
    localparam int SEED              = 86978;
    localparam     STIM_FILE         = "execution_unit_stim.txt";

    logic       clk;
    logic       rst;
    logic       issue_valid;
    exu_unit_t  issue_unit;
    logic [2:0] issue_opcode;
    tag_t       issue_tag;
    data_word_t operand_a;
    data_word_t operand_b;
    logic       machine_return;
    logic       itu_valid;
    tag_t       itu_tag;
    data_word_t itu_result;
    logic       ldu_valid;
    tag_t       ldu_tag;
    data_word_t ldu_data;
    logic       ld_credit;
    logic       st_credit;
    logic       csr_valid;
    tag_t       csr_tag;
    data_word_t csr_result;
    logic       csr_illegal;

    // Seven words per record, see the column note at the top of the file
    logic [31:0] stim_mem [FIELDS*MAX_RECORDS];
    int          n_records;
    logic        loaded;

    // Scoreboard indexed by tag
    logic        pending     [16];
    exu_unit_t   exp_unit    [16];
    data_word_t  exp_value   [16];
    logic        exp_illegal [16];
    int          issue_cycle [16];
    int          outstanding;

    // Rising edges seen so far, used to measure result latency
    int cycle_count;

    // Credit state as seen by the sender
    int ld_credits;
    int st_credits;

    tb_clock_gen #(.PERIOD_NS(4)) clock_gen_i (
        .clk_o (clk)
    );

    execution_unit #(.STORE_BUFFER_SIZE(STORE_BUFFER_SIZE)) execution_unit_i (
        .clk_i            (clk),
        .rst_i            (rst),
        .issue_valid_i    (issue_valid),
        .issue_unit_i     (issue_unit),
        .issue_opcode_i   (issue_opcode),
        .issue_tag_i      (issue_tag),
        .operand_a_i      (operand_a),
        .operand_b_i      (operand_b),
        .machine_return_i (machine_return),
        .itu_valid_o      (itu_valid),
        .itu_tag_o        (itu_tag),
        .itu_result_o     (itu_result),
        .ldu_valid_o      (ldu_valid),
        .ldu_tag_o        (ldu_tag),
        .ldu_data_o       (ldu_data),
        .ld_credit_o      (ld_credit),
        .st_credit_o      (st_credit),
        .csr_valid_o      (csr_valid),
        .csr_tag_o        (csr_tag),
        .csr_result_o     (csr_result),
        .csr_illegal_o    (csr_illegal)
    );

    //==============================
    // Helpers
    //==============================

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "Run stopped after a failed check");
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_result(input exu_unit_t unit, input tag_t tag,
                                input data_word_t value, input logic illegal);
        assert (pending[tag] && exp_unit[tag] == unit)
            else fail_run($sformatf("Unit %0d returned tag %0d which was not in flight",
                                    unit, tag));
        // Integer and CSR results take exactly one cycle, a load at least two
        assert (unit == UNIT_LOAD ? cycle_count >= issue_cycle[tag] + 2
                                  : cycle_count == issue_cycle[tag] + 1)
            else fail_run($sformatf("Tag %0d came back %0d cycles after its issue",
                                    tag, cycle_count - issue_cycle[tag]));
        assert (value == exp_value[tag] && illegal == exp_illegal[tag])
            else fail_run($sformatf("MISMATCH at time %0t: tag %0d got %h/%b, expected %h/%b",
                                    $time, tag, value, illegal,
                                    exp_value[tag], exp_illegal[tag]));
        pending[tag] = 1'b0;
        outstanding--;
    endtask

    // Waits until every result is back and every credit has returned
    task automatic wait_for_drain();
        while (outstanding != 0 || ld_credits != 1 || st_credits != STORE_BUFFER_SIZE) begin
            next_cycle();
        end
    endtask

    task automatic issue_record(input int r);
        int         base;
        int         gap;
        exu_unit_t  unit;
        tag_t       tag;
        logic [3:0] flags;
        base  = FIELDS * r;
        unit  = exu_unit_t'(stim_mem[base][1:0]);
        tag   = stim_mem[base+2][3:0];
        flags = stim_mem[base+5][3:0];
        // Flag bit 2 keeps the issue back to back with the previous one
        if (!flags[2]) begin
            gap = $urandom % 4;
            repeat (gap) next_cycle();
        end
        if (flags[3]) begin
            wait_for_drain();
        end
        // Hold the operation while its unit has no credit
        case (unit)
            UNIT_LOAD:  while (ld_credits == 0) next_cycle();
            UNIT_STORE: while (st_credits == 0) next_cycle();
            default:    ;
        endcase
        // A tag is reused only after its earlier result came back
        if (unit != UNIT_STORE) begin
            while (pending[tag]) next_cycle();
        end
        if (flags[1]) begin
            machine_return = 1'b1;
            next_cycle();
            machine_return = 1'b0;
        end
        issue_valid  = 1'b1;
        issue_unit   = unit;
        issue_opcode = stim_mem[base+1][2:0];
        issue_tag    = tag;
        operand_a    = stim_mem[base+3];
        operand_b    = stim_mem[base+4];
        if (unit == UNIT_LOAD) begin
            ld_credits--;
        end
        if (unit == UNIT_STORE) begin
            st_credits--;
        end else begin
            pending[tag]     = 1'b1;
            exp_unit[tag]    = unit;
            exp_value[tag]   = stim_mem[base+6];
            exp_illegal[tag] = flags[0];
            issue_cycle[tag] = cycle_count;
            outstanding++;
        end
        next_cycle();
        issue_valid = 1'b0;
    endtask

    //==============================
    // Stimulus
    //==============================

    initial begin
        rst            = 1'b1;
        issue_valid    = 1'b0;
        issue_unit     = UNIT_ITU;
        issue_opcode   = '0;
        issue_tag      = '0;
        operand_a      = '0;
        operand_b      = '0;
        machine_return = 1'b0;
        loaded         = 1'b0;
        n_records      = 0;
        outstanding    = 0;
        cycle_count    = 0;
        ld_credits     = 1;
        st_credits     = STORE_BUFFER_SIZE;
        for (int t = 0; t < 16; t++) begin
            pending[t] = 1'b0;
        end
        for (int i = 0; i < FIELDS * MAX_RECORDS; i++) begin
            stim_mem[i] = '0;
        end
        $readmemh(STIM_FILE, stim_mem);
        // A unit field of F ends the record list
        while (n_records < MAX_RECORDS && stim_mem[FIELDS*n_records] != 32'hF) begin
            n_records++;
        end
        loaded = 1'b1;
        assert (n_records > 0)
            else fail_run("The stimulus file holds no records");
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        for (int r = 0; r < n_records; r++) begin
            issue_record(r);
        end
        wait_for_drain();
        $display("Verification passed");
        $finish;
    end

    //==============================
    // Result and credit monitor
    //==============================

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // Sampled on the falling edge where all outputs are settled
    always @(negedge clk) begin
        if (rst) begin
            assert (!itu_valid && !ldu_valid && !csr_valid && !ld_credit && !st_credit)
                else fail_run("A valid or credit output was active during reset");
        end else begin
            if (itu_valid) check_result(UNIT_ITU, itu_tag, itu_result, 1'b0);
            if (ldu_valid) check_result(UNIT_LOAD, ldu_tag, ldu_data, 1'b0);
            if (csr_valid) check_result(UNIT_CSR, csr_tag, csr_result, csr_illegal);
            if (ld_credit) begin
                ld_credits++;
            end
            if (st_credit) begin
                st_credits++;
            end
            assert (ld_credits <= 1 && st_credits <= STORE_BUFFER_SIZE)
                else fail_run("More credits came back than operations were issued");
        end
    end

    // Watchdog sized from the number of records
    initial begin
        wait (loaded);
        repeat (RESET_CYCLES + CYCLES_PER_RECORD * n_records) @(posedge clk);
        fail_run($sformatf("Timeout: the run did not finish within %0d cycles",
                           RESET_CYCLES + CYCLES_PER_RECORD * n_records));
    end

endmodule : tb_execution_unit
